/* design/vpu_defines.svh */
`ifndef VPU_DEFINES_SVH
`define VPU_DEFINES_SVH

// memory and register file sizes
`define VPU_IMEM_DEPTH 256
`define VPU_DMEM_DEPTH 1024
`define VPU_NREGS      32
`define VPU_LANES      4

// host byte-address map, each word takes 4 bytes
`define VPU_IMEM_BASE  16'h0000
`define VPU_DMEM_BASE  16'h1000
`define VPU_CTRL_ADDR  16'h2000

`endif

/* design/vpu_pkg.sv */
package vpu_pkg;

	// instruction: opcode 19:15, rd or label 14:10, rs2 9:5, rs1 4:0
	typedef logic [19:0] instr_t;
	typedef logic [7:0]  pc_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [15:0] sword_t;
	typedef logic [7:0]  lane_t;
	// one vector register, also one data memory word
	typedef logic [31:0] vword_t;
	typedef logic [9:0]  dmem_addr_t;

	typedef enum logic [4:0] {
		NOP = 5'd0,
		ADD, SUB, AND, OR, XOR,
		LI, LW, SW,
		BEQ, BNE,
		VADD, VSUB, VXOR, VBCAST,
		VLD, VST,
		HALT
	} opcode_t;

	typedef enum logic [1:0] {
		IDLE,
		WAIT_GRANT,
		WAIT_DATA,
		RESPOND
	} host_state_t;

endpackage

/* design/data_ram.sv */
`timescale 1ns/1ps
`include "vpu_defines.svh"

module data_ram (
	input  logic                clk,
	input  logic                we,
	input  vpu_pkg::dmem_addr_t addr,
	input  vpu_pkg::vword_t     wdata,
	output vpu_pkg::vword_t     rdata
);
	import vpu_pkg::*;

	vword_t mem [`VPU_DMEM_DEPTH];

	// read returns the old word on a same-address write
	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

/* design/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                clk,
	input  logic                rst,
	input  logic                core_req,
	input  logic                core_we,
	input  vpu_pkg::dmem_addr_t core_addr,
	input  vpu_pkg::vword_t     core_wdata,
	input  logic                host_req,
	input  logic                host_we,
	input  vpu_pkg::dmem_addr_t host_addr,
	input  vpu_pkg::vword_t     host_wdata,
	output logic                host_gnt,
	output logic                host_rvalid,
	output vpu_pkg::vword_t     host_rdata,
	output vpu_pkg::vword_t     core_rdata,
	output logic                ram_we,
	output vpu_pkg::dmem_addr_t ram_addr,
	output vpu_pkg::vword_t     ram_wdata,
	input  vpu_pkg::vword_t     ram_rdata
);
	// set when last cycle was a granted host read
	logic host_rd_q;

	// core never waits, host gets the idle cycles
	assign host_gnt  = host_req && !core_req;
	assign ram_we    = core_req ? core_we : (host_gnt && host_we);
	assign ram_addr  = core_req ? core_addr : host_addr;
	assign ram_wdata = core_req ? core_wdata : host_wdata;

	always_ff @(posedge clk) begin
		if (rst)
			host_rd_q <= 1'b0;
		else
			host_rd_q <= host_gnt && !host_we;
	end

	// route the returning word to whoever read it
	assign host_rvalid = host_rd_q;
	assign host_rdata  = host_rd_q ? ram_rdata : '0;
	assign core_rdata  = host_rd_q ? '0 : ram_rdata;

endmodule

/* design/register_files.sv */
`timescale 1ns/1ps
`include "vpu_defines.svh"

module register_files (
	input  logic              clk,
	input  vpu_pkg::reg_addr_t rs1,
	input  vpu_pkg::reg_addr_t rs2,
	output vpu_pkg::sword_t   srd1,
	output vpu_pkg::sword_t   srd2,
	output vpu_pkg::vword_t   vrd1,
	output vpu_pkg::vword_t   vrd2,
	input  logic              s_we,
	input  logic              v_we,
	input  vpu_pkg::reg_addr_t wr_addr,
	input  vpu_pkg::sword_t   s_wdata,
	input  vpu_pkg::vword_t   v_wdata
);
	import vpu_pkg::*;

	sword_t sregs [`VPU_NREGS];
	vword_t vregs [`VPU_NREGS];

	// both banks share the write address
	always_ff @(posedge clk) begin
		if (s_we)
			sregs[wr_addr] <= s_wdata;
		if (v_we)
			vregs[wr_addr] <= v_wdata;
	end

	assign srd1 = sregs[rs1];
	assign srd2 = sregs[rs2];
	assign vrd1 = vregs[rs1];
	assign vrd2 = vregs[rs2];

endmodule

/* design/fetch_unit.sv */
`timescale 1ns/1ps
`include "vpu_defines.svh"

module fetch_unit (
	input  logic            clk,
	input  logic            rst,
	input  logic            start,
	input  logic            imem_we,
	input  vpu_pkg::pc_t    imem_addr,
	input  vpu_pkg::instr_t imem_data,
	input  logic            halt,
	input  logic            redirect,
	input  vpu_pkg::pc_t    redirect_pc,
	output logic            running,
	output vpu_pkg::instr_t instr,
	output vpu_pkg::pc_t    instr_pc,
	output logic            instr_valid
);
	import vpu_pkg::*;

	instr_t imem [`VPU_IMEM_DEPTH];
	pc_t    pc;

	// host loads a program only while the core is stopped
	always_ff @(posedge clk) begin
		if (imem_we && !running)
			imem[imem_addr] <= imem_data;
		instr    <= imem[pc];
		instr_pc <= pc;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc          <= '0;
			running     <= 1'b0;
			instr_valid <= 1'b0;
		end else if (start) begin
			pc          <= '0;
			running     <= 1'b1;
			instr_valid <= 1'b0;
		end else if (halt) begin
			running     <= 1'b0;
			instr_valid <= 1'b0;
		end else begin
			// the instruction fetched behind a taken branch is dropped
			instr_valid <= running && !redirect;
			if (redirect)
				pc <= redirect_pc;
			else if (running)
				pc <= pc + 1'b1;
		end
	end

endmodule

/* design/execute_unit.sv */
`timescale 1ns/1ps
`include "vpu_defines.svh"

module execute_unit (
	input  logic                clk,
	input  logic                rst,
	input  vpu_pkg::instr_t     instr,
	input  vpu_pkg::pc_t        instr_pc,
	input  logic                instr_valid,
	output vpu_pkg::reg_addr_t  rs1,
	output vpu_pkg::reg_addr_t  rs2,
	input  vpu_pkg::sword_t     srd1,
	input  vpu_pkg::sword_t     srd2,
	input  vpu_pkg::vword_t     vrd1,
	input  vpu_pkg::vword_t     vrd2,
	output logic                halt,
	output logic                redirect,
	output vpu_pkg::pc_t        redirect_pc,
	output logic                core_req,
	output logic                core_we,
	output vpu_pkg::dmem_addr_t core_addr,
	output vpu_pkg::vword_t     core_wdata,
	input  vpu_pkg::vword_t     core_rdata,
	output logic                s_we,
	output logic                v_we,
	output vpu_pkg::reg_addr_t  wr_addr,
	output vpu_pkg::sword_t     s_wdata,
	output vpu_pkg::vword_t     v_wdata
);
	import vpu_pkg::*;

	opcode_t   op;
	reg_addr_t rd;
	sword_t    s_a, s_b, s_res, wb_s_res;
	vword_t    v_a, v_b, v_res, wb_v_res;
	logic      s_wr, v_wr, is_load, mem_op, mem_wr, take, halt_op;
	logic      wb_load;

	assign op  = opcode_t'(instr[19:15]);
	assign rd  = instr[14:10];
	assign rs2 = instr[9:5];
	assign rs1 = instr[4:0];

	//////////////////////////////////////////////////////////////////////
	// forwarding from the writeback stage

	assign s_a = (s_we && wr_addr == rs1) ? s_wdata : srd1;
	assign s_b = (s_we && wr_addr == rs2) ? s_wdata : srd2;
	assign v_a = (v_we && wr_addr == rs1) ? v_wdata : vrd1;
	assign v_b = (v_we && wr_addr == rs2) ? v_wdata : vrd2;

	//////////////////////////////////////////////////////////////////////
	// decode and scalar ALU

	always_comb begin
		s_res   = '0;
		s_wr    = 1'b0;
		v_wr    = 1'b0;
		is_load = 1'b0;
		mem_op  = 1'b0;
		mem_wr  = 1'b0;
		take    = 1'b0;
		halt_op = 1'b0;
		case (op)
			ADD: begin s_res = s_a + s_b; s_wr = 1'b1; end
			SUB: begin s_res = s_a - s_b; s_wr = 1'b1; end
			AND: begin s_res = s_a & s_b; s_wr = 1'b1; end
			OR:  begin s_res = s_a | s_b; s_wr = 1'b1; end
			XOR: begin s_res = s_a ^ s_b; s_wr = 1'b1; end
			LI:  begin s_res = sword_t'(instr[9:0]); s_wr = 1'b1; end
			LW: begin
				s_wr    = 1'b1;
				is_load = 1'b1;
				mem_op  = 1'b1;
			end
			SW: begin
				mem_op = 1'b1;
				mem_wr = 1'b1;
			end
			BEQ: take = (s_a == s_b);
			BNE: take = (s_a != s_b);
			VADD, VSUB, VXOR, VBCAST: v_wr = 1'b1;
			VLD: begin
				v_wr    = 1'b1;
				is_load = 1'b1;
				mem_op  = 1'b1;
			end
			VST: begin
				mem_op = 1'b1;
				mem_wr = 1'b1;
			end
			HALT: halt_op = 1'b1;
			default: ;
		endcase
	end

	// lanewise vector ALU, each lane wraps at 8 bits
	always_comb begin
		lane_t la, lb, lr;
		v_res = '0;
		for (int i = 0; i < `VPU_LANES; i++) begin
			la = v_a[8*i +: 8];
			lb = v_b[8*i +: 8];
			case (op)
				VADD:    lr = la + lb;
				VSUB:    lr = la - lb;
				VXOR:    lr = la ^ lb;
				default: lr = s_a[7:0];
			endcase
			v_res[8*i +: 8] = lr;
		end
	end

	// branch target is behind the branch by the label
	assign redirect    = instr_valid && take;
	assign redirect_pc = instr_pc - pc_t'(rd);
	assign halt        = instr_valid && halt_op;

	assign core_req   = instr_valid && mem_op;
	assign core_we    = mem_wr;
	assign core_addr  = s_a[9:0];
	assign core_wdata = (op == VST) ? v_b : {16'b0, s_b};

	//////////////////////////////////////////////////////////////////////
	// writeback register

	always_ff @(posedge clk) begin
		if (rst) begin
			s_we    <= 1'b0;
			v_we    <= 1'b0;
			wb_load <= 1'b0;
		end else begin
			s_we    <= instr_valid && s_wr;
			v_we    <= instr_valid && v_wr;
			wb_load <= instr_valid && is_load;
		end
	end

	always_ff @(posedge clk) begin
		wr_addr  <= rd;
		wb_s_res <= s_res;
		wb_v_res <= v_res;
	end

	// load data arrives from memory during writeback
	assign s_wdata = wb_load ? core_rdata[15:0] : wb_s_res;
	assign v_wdata = wb_load ? core_rdata : wb_v_res;

endmodule

/* design/axil_host_port.sv */
`timescale 1ns/1ps
`include "vpu_defines.svh"

module axil_host_port (
	input  logic                clk,
	input  logic                rst,
	input  logic [15:0]         awaddr,
	input  logic                awvalid,
	output logic                awready,
	input  logic [31:0]         wdata,
	input  logic                wvalid,
	output logic                wready,
	output logic [1:0]          bresp,
	output logic                bvalid,
	input  logic                bready,
	input  logic [15:0]         araddr,
	input  logic                arvalid,
	output logic                arready,
	output logic [31:0]         rdata,
	output logic [1:0]          rresp,
	output logic                rvalid,
	input  logic                rready,
	output logic                imem_we,
	output vpu_pkg::pc_t        imem_addr,
	output vpu_pkg::instr_t     imem_data,
	output logic                start,
	input  logic                running,
	input  logic                halted,
	output logic                host_req,
	output logic                host_we,
	output vpu_pkg::dmem_addr_t host_addr,
	output vpu_pkg::vword_t     host_wdata,
	input  logic                host_gnt,
	input  logic                host_rvalid,
	input  vpu_pkg::vword_t     host_rdata
);
	import vpu_pkg::*;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	host_state_t state;
	logic        wr_acc, rd_acc, is_rd, halted_q;
	logic        hit_ctrl, hit_imem, hit_dmem;
	logic [15:0] acc_addr, imem_off, dmem_off;
	logic [1:0]  resp_q;
	vword_t      rdata_q;

	// one transaction at a time, writes win over reads
	assign wr_acc  = (state == IDLE) && awvalid && wvalid;
	assign rd_acc  = (state == IDLE) && arvalid && !(awvalid && wvalid);
	assign awready = wr_acc;
	assign wready  = wr_acc;
	assign arready = rd_acc;

	// address decode
	assign acc_addr = wr_acc ? awaddr : araddr;
	assign imem_off = acc_addr - `VPU_IMEM_BASE;
	assign dmem_off = acc_addr - `VPU_DMEM_BASE;
	assign hit_ctrl = (acc_addr == `VPU_CTRL_ADDR);
	assign hit_imem = (imem_off < 16'(`VPU_IMEM_DEPTH * 4));
	assign hit_dmem = (dmem_off < 16'(`VPU_DMEM_DEPTH * 4));

	assign bvalid   = (state == RESPOND) && !is_rd;
	assign rvalid   = (state == RESPOND) && is_rd;
	assign bresp    = resp_q;
	assign rresp    = resp_q;
	assign rdata    = rdata_q;
	assign host_req = (state == WAIT_GRANT);
	assign host_we  = !is_rd;

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= IDLE;
			is_rd    <= 1'b0;
			resp_q   <= RESP_OKAY;
			start    <= 1'b0;
			imem_we  <= 1'b0;
			halted_q <= 1'b0;
		end else begin
			start   <= 1'b0;
			imem_we <= 1'b0;
			// halted is sticky until the next start
			if (start)
				halted_q <= 1'b0;
			else if (halted)
				halted_q <= 1'b1;
			case (state)
				IDLE: begin
					if (wr_acc || rd_acc) begin
						is_rd <= rd_acc;
						// instruction memory is write only from the host
						if (hit_ctrl || hit_dmem || (hit_imem && wr_acc))
							resp_q <= RESP_OKAY;
						else
							resp_q <= RESP_SLVERR;
						state   <= hit_dmem ? WAIT_GRANT : RESPOND;
						start   <= wr_acc && hit_ctrl && wdata[0];
						imem_we <= wr_acc && hit_imem;
					end
				end
				WAIT_GRANT: begin
					if (host_gnt)
						state <= is_rd ? WAIT_DATA : RESPOND;
				end
				WAIT_DATA: begin
					if (host_rvalid)
						state <= RESPOND;
				end
				RESPOND: begin
					if (is_rd ? rready : bready)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// request payload and read data
	always_ff @(posedge clk) begin
		if (wr_acc || rd_acc) begin
			imem_addr  <= pc_t'(imem_off >> 2);
			imem_data  <= wdata[19:0];
			host_addr  <= dmem_addr_t'(dmem_off >> 2);
			host_wdata <= wdata;
			rdata_q    <= hit_ctrl ? {30'b0, halted_q, running} : '0;
		end else if (state == WAIT_DATA && host_rvalid) begin
			rdata_q <= host_rdata;
		end
	end

endmodule

/* design/vpu_top.sv */
`timescale 1ns/1ps

module vpu_top (
	input  logic        clk,
	input  logic        rst,
	input  logic [15:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [15:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready
);
	import vpu_pkg::*;

	// host to fetch
	logic       imem_we, start, running;
	pc_t        imem_addr;
	instr_t     imem_data;
	// fetch to execute
	instr_t     instr;
	pc_t        instr_pc, redirect_pc;
	logic       instr_valid, halt, redirect;
	// register file
	reg_addr_t  rs1, rs2, wr_addr;
	sword_t     srd1, srd2, s_wdata;
	vword_t     vrd1, vrd2, v_wdata;
	logic       s_we, v_we;
	// data memory sharing
	logic       core_req, core_we, host_req, host_we, host_gnt, host_rvalid, ram_we;
	dmem_addr_t core_addr, host_addr, ram_addr;
	vword_t     core_wdata, core_rdata, host_wdata, host_rdata, ram_wdata, ram_rdata;

	//////////////////////////////////////////////////////////////////////
	// host side

	axil_host_port u_host (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
		.start(start), .running(running), .halted(halt),
		.host_req(host_req), .host_we(host_we), .host_addr(host_addr),
		.host_wdata(host_wdata), .host_gnt(host_gnt),
		.host_rvalid(host_rvalid), .host_rdata(host_rdata)
	);

	//////////////////////////////////////////////////////////////////////
	// core pipeline

	fetch_unit u_fetch (
		.clk(clk), .rst(rst), .start(start),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
		.halt(halt), .redirect(redirect), .redirect_pc(redirect_pc),
		.running(running), .instr(instr), .instr_pc(instr_pc),
		.instr_valid(instr_valid)
	);

	register_files u_regs (
		.clk(clk), .rs1(rs1), .rs2(rs2),
		.srd1(srd1), .srd2(srd2), .vrd1(vrd1), .vrd2(vrd2),
		.s_we(s_we), .v_we(v_we), .wr_addr(wr_addr),
		.s_wdata(s_wdata), .v_wdata(v_wdata)
	);

	execute_unit u_exec (
		.clk(clk), .rst(rst),
		.instr(instr), .instr_pc(instr_pc), .instr_valid(instr_valid),
		.rs1(rs1), .rs2(rs2),
		.srd1(srd1), .srd2(srd2), .vrd1(vrd1), .vrd2(vrd2),
		.halt(halt), .redirect(redirect), .redirect_pc(redirect_pc),
		.core_req(core_req), .core_we(core_we), .core_addr(core_addr),
		.core_wdata(core_wdata), .core_rdata(core_rdata),
		.s_we(s_we), .v_we(v_we), .wr_addr(wr_addr),
		.s_wdata(s_wdata), .v_wdata(v_wdata)
	);

	//////////////////////////////////////////////////////////////////////
	// shared data memory

	mem_arbiter u_arb (
		.clk(clk), .rst(rst),
		.core_req(core_req), .core_we(core_we), .core_addr(core_addr),
		.core_wdata(core_wdata),
		.host_req(host_req), .host_we(host_we), .host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_gnt(host_gnt), .host_rvalid(host_rvalid), .host_rdata(host_rdata),
		.core_rdata(core_rdata),
		.ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata)
	);

	data_ram u_dmem (
		.clk(clk), .we(ram_we), .addr(ram_addr),
		.wdata(ram_wdata), .rdata(ram_rdata)
	);

endmodule

/* tb/vpu_sva.sv */
`timescale 1ns/1ps

module vpu_sva (
	input logic        clk,
	input logic        rst,
	input logic        awready,
	input logic        wready,
	input logic        arready,
	input logic [1:0]  bresp,
	input logic        bvalid,
	input logic        bready,
	input logic [31:0] rdata,
	input logic [1:0]  rresp,
	input logic        rvalid,
	input logic        rready
);

	write_resp_held: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("write response dropped or changed before bready");

	read_resp_held: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else $error("read response dropped or changed before rready");

	reset_quiet: assert property (@(posedge clk)
		rst |=> !bvalid && !rvalid && !awready && !wready && !arready)
		else $error("handshake signals active after reset");

endmodule

bind vpu_top vpu_sva u_sva (
	.clk(clk),
	.rst(rst),
	.awready(awready),
	.wready(wready),
	.arready(arready),
	.bresp(bresp),
	.bvalid(bvalid),
	.bready(bready),
	.rdata(rdata),
	.rresp(rresp),
	.rvalid(rvalid),
	.rready(rready)
);

/* tb/vpu_tb.sv */
`timescale 1ns/1ps
`include "vpu_defines.svh"

module vpu_tb;
	import vpu_pkg::*;

	localparam int         CLK_PERIOD      = 100;
	localparam int         NUM_TESTS       = 6;
	localparam int         CYCLES_PER_TEST = 4000;
	localparam int         HS_LIMIT        = 200;
	localparam int         POLL_LIMIT      = 1000;
	localparam int         MODEL_STEPS     = 4096;
	localparam int         WIN_WORDS       = 32;
	localparam logic [9:0] WIN             = 10'h100;
	localparam logic [9:0] SPARE           = 10'h3F0;
	localparam logic [1:0] OKAY            = 2'b00;
	localparam logic [1:0] SLVERR          = 2'b10;

	logic        clk = 1'b0;
	logic        rst;
	logic [15:0] awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [15:0] araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;

	logic [15:0] lfsr;
	int          errors;
	int          checks;
	int          errs_before;

	// program image and instruction-set model state
	instr_t      prog [`VPU_IMEM_DEPTH];
	int          prog_len;
	sword_t      m_s [`VPU_NREGS];
	vword_t      m_v [`VPU_NREGS];
	vword_t      model_mem [`VPU_DMEM_DEPTH];

	vpu_top UUT (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	initial begin
		#(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
		$display("watchdog expired, the tests did not finish in time");
		$display("Simulation FAILED");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// random numbers and checks

	// 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		checks++;
		assert (got === exp) else begin
			$display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input int num, input string name, input int errs);
		if (errors == errs)
			$display("test %0d %s: ok", num, name);
		else
			$display("test %0d %s: %0d errors", num, name, errors - errs);
	endtask

	//////////////////////////////////////////////////////////////////////
	// AXI4-Lite host tasks

	task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int n;
		int hold;
		n = 0;
		hold = rand_bits(2);
		@(negedge clk);
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		@(posedge clk);
		while (!awready && n < HS_LIMIT) begin
			@(posedge clk);
			n++;
		end
		@(negedge clk);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		// response back-pressure for a few cycles
		repeat (hold) @(negedge clk);
		bready  = 1'b1;
		@(posedge clk);
		while (!bvalid && n < HS_LIMIT) begin
			@(posedge clk);
			n++;
		end
		resp = bresp;
		if (n >= HS_LIMIT) begin
			$display("write to %h got no handshake from the DUT at %0t", addr, $time);
			errors++;
			resp = 2'bxx;
		end
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [15:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int n;
		int hold;
		n = 0;
		hold = rand_bits(2);
		@(negedge clk);
		araddr  = addr;
		arvalid = 1'b1;
		@(posedge clk);
		while (!arready && n < HS_LIMIT) begin
			@(posedge clk);
			n++;
		end
		@(negedge clk);
		arvalid = 1'b0;
		// read data back-pressure for a few cycles
		repeat (hold) @(negedge clk);
		rready  = 1'b1;
		@(posedge clk);
		while (!rvalid && n < HS_LIMIT) begin
			@(posedge clk);
			n++;
		end
		data = rdata;
		resp = rresp;
		if (n >= HS_LIMIT) begin
			$display("read of %h got no handshake from the DUT at %0t", addr, $time);
			errors++;
			data = 'x;
			resp = 2'bxx;
		end
		@(negedge clk);
		rready = 1'b0;
	endtask

	function automatic logic [15:0] dmem_byte(input logic [9:0] word);
		return `VPU_DMEM_BASE + {4'b0, word, 2'b00};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// program building and the instruction-set model

	function automatic instr_t enc(input opcode_t op, input logic [4:0] rd,
			input logic [4:0] rs2, input logic [4:0] rs1);
		return {op, rd, rs2, rs1};
	endfunction

	function automatic instr_t enc_li(input logic [4:0] rd, input logic [9:0] imm);
		return {LI, rd, imm};
	endfunction

	function automatic opcode_t random_alu();
		return opcode_t'(5'd1 + 5'(rand_bits(3) % 5));
	endfunction

	task automatic emit(input instr_t ins);
		prog[prog_len] = ins;
		prog_len++;
	endtask

	// each lane wraps at 8 bits
	function automatic vword_t lanewise(input opcode_t op, input vword_t a, input vword_t b);
		vword_t r;
		lane_t  x;
		lane_t  y;
		r = '0;
		for (int i = 0; i < `VPU_LANES; i++) begin
			x = a[8*i +: 8];
			y = b[8*i +: 8];
			if (op == VADD)
				r[8*i +: 8] = x + y;
			else if (op == VSUB)
				r[8*i +: 8] = x - y;
			else
				r[8*i +: 8] = x ^ y;
		end
		return r;
	endfunction

	task automatic run_model();
		pc_t        pc;
		pc_t        cur;
		int         steps;
		logic       done;
		instr_t     ins;
		logic [4:0] rd;
		logic [4:0] ra;
		logic [4:0] rb;
		sword_t     a;
		sword_t     b;
		pc = '0;
		steps = 0;
		done = 1'b0;
		while (!done && steps < MODEL_STEPS) begin
			ins = prog[pc];
			rd  = ins[14:10];
			rb  = ins[9:5];
			ra  = ins[4:0];
			a   = m_s[ra];
			b   = m_s[rb];
			cur = pc;
			pc  = pc + 1'b1;
			steps++;
			case (opcode_t'(ins[19:15]))
				ADD:    m_s[rd] = a + b;
				SUB:    m_s[rd] = a - b;
				AND:    m_s[rd] = a & b;
				OR:     m_s[rd] = a | b;
				XOR:    m_s[rd] = a ^ b;
				LI:     m_s[rd] = {6'b0, ins[9:0]};
				LW:     m_s[rd] = model_mem[a[9:0]][15:0];
				SW:     model_mem[a[9:0]] = {16'b0, b};
				BEQ:    if (a == b) pc = cur - pc_t'(rd);
				BNE:    if (a != b) pc = cur - pc_t'(rd);
				VADD:   m_v[rd] = lanewise(VADD, m_v[ra], m_v[rb]);
				VSUB:   m_v[rd] = lanewise(VSUB, m_v[ra], m_v[rb]);
				VXOR:   m_v[rd] = lanewise(VXOR, m_v[ra], m_v[rb]);
				VBCAST: m_v[rd] = {4{a[7:0]}};
				VLD:    m_v[rd] = model_mem[a[9:0]];
				VST:    model_mem[a[9:0]] = m_v[rb];
				HALT:   done = 1'b1;
				default: ;
			endcase
		end
		if (!done) begin
			$display("model ran %0d steps without reaching HALT", steps);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequences

	task automatic init_window();
		logic [31:0] w;
		logic [1:0]  resp;
		for (int i = 0; i < WIN_WORDS; i++) begin
			w = rand_bits(32);
			axi_write(dmem_byte(WIN + 10'(i)), w, resp);
			model_mem[WIN + 10'(i)] = w;
			check_eq(resp, OKAY, "window write response");
		end
	endtask

	task automatic compare_window();
		logic [31:0] got;
		logic [1:0]  resp;
		for (int i = 0; i < WIN_WORDS; i++) begin
			axi_read(dmem_byte(WIN + 10'(i)), got, resp);
			check_eq(got, model_mem[WIN + 10'(i)], $sformatf("data word %h", WIN + 10'(i)));
			check_eq(resp, OKAY, "window read response");
		end
	endtask

	task automatic load_and_start();
		logic [1:0] resp;
		for (int i = 0; i < prog_len; i++) begin
			axi_write(`VPU_IMEM_BASE + 16'(i * 4), {12'b0, prog[i]}, resp);
			check_eq(resp, OKAY, "instruction write response");
		end
		run_model();
		axi_write(`VPU_CTRL_ADDR, 32'h1, resp);
		check_eq(resp, OKAY, "start write response");
	endtask

	task automatic wait_halted();
		logic [31:0] st;
		logic [1:0]  resp;
		int          polls;
		polls = 0;
		st = '0;
		while (!st[1] && polls < POLL_LIMIT) begin
			axi_read(`VPU_CTRL_ADDR, st, resp);
			polls++;
		end
		if (st[1] !== 1'b1) begin
			$display("core never reported halted after %0d status polls", polls);
			errors++;
		end else begin
			check_eq(st, 32'h2, "status after halt");
		end
	endtask

	task automatic test_reset();
		logic [31:0] st;
		logic [1:0]  resp;
		@(negedge clk);
		check_eq(bvalid, 1'b0, "bvalid after reset");
		check_eq(rvalid, 1'b0, "rvalid after reset");
		axi_read(`VPU_CTRL_ADDR, st, resp);
		check_eq(st, 32'h0, "status after reset");
		check_eq(resp, OKAY, "status read response");
	endtask

	task automatic test_host_memory();
		logic [9:0]  addr [16];
		logic [31:0] w;
		logic [31:0] got;
		logic [1:0]  resp;
		for (int i = 0; i < 16; i++) begin
			addr[i] = 10'(rand_bits(10));
			w = rand_bits(32);
			axi_write(dmem_byte(addr[i]), w, resp);
			model_mem[addr[i]] = w;
			check_eq(resp, OKAY, "data write response");
		end
		for (int i = 0; i < 16; i++) begin
			axi_read(dmem_byte(addr[i]), got, resp);
			check_eq(got, model_mem[addr[i]], $sformatf("readback of word %h", addr[i]));
			check_eq(resp, OKAY, "data read response");
		end
		axi_write(16'h3000, rand_bits(32), resp);
		check_eq(resp, SLVERR, "unmapped write response");
		axi_read(16'h0800, got, resp);
		check_eq(resp, SLVERR, "unmapped read response");
		// instruction memory is write only from the host
		axi_read(`VPU_IMEM_BASE + 16'h0010, got, resp);
		check_eq(resp, SLVERR, "instruction memory read response");
	endtask

	task automatic test_scalar();
		logic [4:0] rd;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [4:0] last;
		logic [2:0] kind;
		prog_len = 0;
		last = '0;
		for (int i = 0; i < 16; i++)
			emit(enc_li(5'(i), 10'(rand_bits(10))));
		for (int n = 0; n < 40; n++) begin
			kind = 3'(rand_bits(3));
			rd   = 5'(rand_bits(4));
			rb   = 5'(rand_bits(4));
			// often reuse the last result to get back-to-back dependencies
			ra   = rand_bits(1) ? last : 5'(rand_bits(4));
			case (kind)
				3'd5: emit(enc_li(rd, 10'(rand_bits(10))));
				3'd6: begin
					emit(enc_li(5'd31, WIN + 10'(rand_bits(5))));
					emit(enc(LW, rd, 5'd0, 5'd31));
					// loaded value used right away
					emit(enc(random_alu(), rb, ra, rd));
					rd = rb;
				end
				3'd7: begin
					emit(enc_li(5'd31, WIN + 10'(rand_bits(5))));
					emit(enc(SW, 5'd0, rb, 5'd31));
				end
				default: emit(enc(random_alu(), rd, rb, ra));
			endcase
			last = rd;
		end
		for (int i = 0; i < 16; i++) begin
			emit(enc_li(5'd31, WIN + 10'(i)));
			emit(enc(SW, 5'd0, 5'(i), 5'd31));
		end
		emit(enc(HALT, 5'd0, 5'd0, 5'd0));
		init_window();
		load_and_start();
		wait_halted();
		compare_window();
	endtask

	task automatic test_vector();
		logic [4:0] vd;
		logic [4:0] va;
		logic [4:0] vb;
		logic [4:0] last;
		logic [2:0] kind;
		prog_len = 0;
		last = '0;
		for (int i = 0; i < 8; i++) begin
			emit(enc_li(5'd31, WIN + 10'(i)));
			emit(enc(VLD, 5'(i), 5'd0, 5'd31));
		end
		for (int n = 0; n < 30; n++) begin
			kind = 3'(rand_bits(3));
			vd   = 5'(rand_bits(3));
			vb   = 5'(rand_bits(3));
			va   = rand_bits(1) ? last : 5'(rand_bits(3));
			case (kind)
				3'd0, 3'd1: emit(enc(VADD, vd, vb, va));
				3'd2, 3'd3: emit(enc(VSUB, vd, vb, va));
				3'd4: emit(enc(VXOR, vd, vb, va));
				3'd5: begin
					emit(enc_li(5'd30, 10'(rand_bits(10))));
					emit(enc(VBCAST, vd, 5'd0, 5'd30));
				end
				3'd6: begin
					emit(enc_li(5'd31, WIN + 10'(rand_bits(5))));
					emit(enc(VLD, vd, 5'd0, 5'd31));
				end
				default: begin
					emit(enc_li(5'd31, WIN + 10'(rand_bits(5))));
					emit(enc(VST, 5'd0, vb, 5'd31));
				end
			endcase
			last = vd;
		end
		for (int i = 0; i < 8; i++) begin
			emit(enc_li(5'd31, WIN + 10'(16 + i)));
			emit(enc(VST, 5'd0, 5'(i), 5'd31));
		end
		emit(enc(HALT, 5'd0, 5'd0, 5'd0));
		init_window();
		load_and_start();
		wait_halted();
		compare_window();
	endtask

	// marker lands at the address held in r2, so a missed flush leaves extra markers
	task automatic test_loop();
		prog_len = 0;
		emit(enc_li(5'd1, 10'(2 + rand_bits(3))));
		emit(enc_li(5'd2, WIN + 10'd16));
		emit(enc_li(5'd3, 10'd1));
		emit(enc_li(5'd4, 10'd0));
		emit(enc_li(5'd6, 10'(rand_bits(10))));
		emit(enc(ADD, 5'd2, 5'd3, 5'd2));
		emit(enc(SUB, 5'd1, 5'd3, 5'd1));
		emit(enc(BNE, 5'd2, 5'd4, 5'd1));
		emit(enc(SW, 5'd0, 5'd6, 5'd2));
		emit(enc_li(5'd31, WIN));
		emit(enc(SW, 5'd0, 5'd1, 5'd31));
		emit(enc_li(5'd31, WIN + 10'd1));
		emit(enc(SW, 5'd0, 5'd2, 5'd31));
		emit(enc(HALT, 5'd0, 5'd0, 5'd0));
		init_window();
		load_and_start();
		wait_halted();
		compare_window();
	endtask

	task automatic test_status_polls();
		logic [31:0] st;
		logic [31:0] got;
		logic [31:0] w;
		logic [1:0]  resp;
		int          polls;
		prog_len = 0;
		for (int i = 0; i < 8; i++)
			emit(enc_li(5'(i), 10'(rand_bits(10))));
		// bursts of stores keep the memory busy every cycle
		for (int g = 0; g < 12; g++) begin
			emit(enc_li(5'd31, WIN + 10'(rand_bits(5))));
			for (int k = 0; k < 4; k++)
				emit(enc(SW, 5'd0, 5'(rand_bits(3)), 5'd31));
		end
		emit(enc(HALT, 5'd0, 5'd0, 5'd0));
		init_window();
		w = rand_bits(32);
		axi_write(dmem_byte(SPARE), w, resp);
		model_mem[SPARE] = w;
		load_and_start();
		polls = 0;
		st = '0;
		while (!st[1] && polls < POLL_LIMIT) begin
			axi_read(`VPU_CTRL_ADDR, st, resp);
			check_eq(resp, OKAY, "status poll response");
			if (polls == 0)
				check_eq(st, 32'h1, "first status poll while running");
			axi_read(dmem_byte(SPARE), got, resp);
			check_eq(got, model_mem[SPARE], "data read during run");
			check_eq(resp, OKAY, "data read response during run");
			polls++;
		end
		check_eq(st, 32'h2, "status after store run");
		compare_window();
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence

	initial begin
		rst     = 1'b1;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		lfsr    = 16'd40986;
		errors  = 0;
		checks  = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		errs_before = errors;
		test_reset();
		report_test(1, "reset state", errs_before);
		errs_before = errors;
		test_host_memory();
		report_test(2, "host data memory access", errs_before);
		errs_before = errors;
		test_scalar();
		report_test(3, "scalar program", errs_before);
		errs_before = errors;
		test_vector();
		report_test(4, "vector program", errs_before);
		errs_before = errors;
		test_loop();
		report_test(5, "branch loop and flush", errs_before);
		errs_before = errors;
		test_status_polls();
		report_test(6, "status polls during stores", errs_before);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* build.f */
+incdir+design
design/vpu_pkg.sv
design/data_ram.sv
design/mem_arbiter.sv
design/register_files.sv
design/fetch_unit.sv
design/execute_unit.sv
design/axil_host_port.sv
design/vpu_top.sv
tb/vpu_sva.sv
tb/vpu_tb.sv

/* Bender.yml */
package:
  name: vpu

export_include_dirs:
  - design

sources:
  - files:
      - design/vpu_pkg.sv
      - design/data_ram.sv
      - design/mem_arbiter.sv
      - design/register_files.sv
      - design/fetch_unit.sv
      - design/execute_unit.sv
      - design/axil_host_port.sv
      - design/vpu_top.sv
  - target: test
    files:
      - tb/vpu_sva.sv
      - tb/vpu_tb.sv
